//--- flist.f
design/timer_pkg.sv
design/hour_counter.sv
design/min_sec_counter.sv
design/countdown_ctrl.sv
design/timer_top.sv
sim/timer_assert.sv
sim/timer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the timer testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module timer_tb -f flist.f -o timer_sim \
	&& ./obj_dir/timer_sim > sim.log 2>&1 \
	|| echo "*** TEST FAILED ***" >> sim.log

cat sim.log

grep -q "TEST FAILED" sim.log \
	&& { echo "timer simulation failed"; exit 1; } \
	|| { echo "timer simulation passed"; exit 0; }

//--- sim/timer_tb.sv
`timescale 1ns/1ps

module timer_tb
	import timer_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 3000; // stimulus needs roughly 500 cycles

	logic       clk;
	logic       reset;
	field_sel_t field;
	logic       up;
	logic       down;
	logic       start;
	logic       clear;
	time_bcd_t  time_out;
	logic       running;
	logic       done;
	int         cycle_count = 0;

	timer_top timer_top_inst (
		.clk      (clk),
		.reset    (reset),
		.field    (field),
		.up       (up),
		.down     (down),
		.start    (start),
		.clear    (clear),
		.time_out (time_out),
		.running  (running),
		.done     (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==============================
	// watchdog
	// ==============================

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timer_top_inst.timer_assert_inst.fail_count != 0) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "a timer check failed before %0t", $time);
		end else if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("*** TEST FAILED ***");
			$fatal(1, "simulation timed out");
		end
	end

	// ==============================
	// stimulus tasks
	// ==============================

	task automatic run_cycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	task automatic apply_reset;
		@(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic strobe_field(input field_sel_t code, input logic step_up);
		@(posedge clk);
		field <= code;
		up    <= step_up;
		down  <= !step_up;
		@(posedge clk);
		up   <= 1'b0;
		down <= 1'b0;
	endtask

	// up and down together, up has priority
	task automatic strobe_both_ways(input field_sel_t code);
		@(posedge clk);
		field <= code;
		up    <= 1'b1;
		down  <= 1'b1;
		@(posedge clk);
		up   <= 1'b0;
		down <= 1'b0;
	endtask

	task automatic random_strobes(input int count);
		logic [3:0] code;
		logic       step_up;
		repeat (count) begin
			code    = 4'($urandom % 16); // invalid codes included
			step_up = 1'($urandom % 2);
			strobe_field(field_sel_t'(code), step_up);
		end
	endtask

	task automatic pulse_start;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic pulse_clear;
		@(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		field = FIELD_SEC;
		up    = 1'b0;
		down  = 1'b0;
		start = 1'b0;
		clear = 1'b0;
		reset = 1'b1;
		void'($urandom(34));
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		run_cycles(2);

		strobe_field(FIELD_HOUR, 1'b0); // 00 wraps to 23
		strobe_field(FIELD_HOUR, 1'b1); // and back to 00
		strobe_field(FIELD_MIN, 1'b0);
		strobe_field(FIELD_MIN, 1'b1);
		strobe_field(FIELD_SEC, 1'b0);
		strobe_field(FIELD_SEC, 1'b1);
		strobe_both_ways(FIELD_MIN); // 00 steps to 01 and not to 59

		strobe_field(field_sel_t'(4'd0), 1'b1); // no field behind these codes
		strobe_field(field_sel_t'(4'd7), 1'b0);
		strobe_field(field_sel_t'(4'd11), 1'b1);
		strobe_field(field_sel_t'(4'd15), 1'b0);
		random_strobes(32);

		// preset 01:01:01 and count down through both borrows
		apply_reset;
		strobe_field(FIELD_HOUR, 1'b1);
		strobe_field(FIELD_MIN, 1'b1);
		strobe_field(FIELD_SEC, 1'b1);
		run_cycles(2);
		pulse_start;
		random_strobes(6); // fields are locked while running
		while (time_out.hour_bcd != 8'h00) @(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;

		// 00:59:59 becomes 00:00:02, then run to zero
		strobe_field(FIELD_MIN, 1'b1);
		strobe_field(FIELD_SEC, 1'b1);
		strobe_field(FIELD_SEC, 1'b1);
		strobe_field(FIELD_SEC, 1'b1);
		pulse_start;
		while (!done) @(posedge clk);
		run_cycles(3);
		pulse_clear;

		pulse_start; // zero time goes straight to done
		while (!done) @(posedge clk);
		pulse_clear;
		run_cycles(3);
		@(negedge clk); // let the last edge's checks settle

		if (timer_top_inst.timer_assert_inst.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "timer checks failed");
		end
	end

endmodule

//--- sim/timer_assert.sv
`timescale 1ns/1ps

module timer_assert
	import timer_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input field_sel_t field,
	input logic       up,
	input logic       down,
	input logic       start,
	input logic       clear,
	input time_bcd_t  time_out,
	input logic       running,
	input logic       done,
	input logic       dec_sec
);

	int   fail_count = 0; // read by the testbench watchdog
	logic hour_strobe;
	logic min_strobe;
	logic sec_strobe;

	assign hour_strobe = !running && (up || down) && (field == FIELD_HOUR);
	assign min_strobe  = !running && (up || down) && (field == FIELD_MIN);
	assign sec_strobe  = !running && (up || down) && (field == FIELD_SEC);

	// ==============================
	// reference arithmetic
	// ==============================

	function automatic int bcd_value(input logic [7:0] bcd);
		return int'(bcd[7:4]) * 10 + int'(bcd[3:0]);
	endfunction

	// up wins when both strobes are high
	function automatic int stepped(input int value, input int span, input logic inc);
		if (inc) return (value + 1) % span;
		return (value + span - 1) % span;
	endfunction

	function automatic int total_seconds(input time_bcd_t t);
		return bcd_value(t.hour_bcd) * 3600 + bcd_value(t.min_bcd) * 60 + bcd_value(t.sec_bcd);
	endfunction

	function automatic logic field_ok(input logic [7:0] bcd, input int limit);
		return (bcd[7:4] <= 4'd9) && (bcd[3:0] <= 4'd9) && (bcd_value(bcd) <= limit);
	endfunction

	// ==============================
	// field adjustment
	// ==============================

	a_hour_adjust: assert property (@(posedge clk) disable iff (reset)
		hour_strobe |=> bcd_value(time_out.hour_bcd) ==
			stepped(bcd_value($past(time_out.hour_bcd)), int'(HOUR_MAX) + 1, $past(up)))
	else begin
		$error("** Error at %0t: hour field stepped to the wrong value", $time);
		fail_count++;
	end

	a_min_adjust: assert property (@(posedge clk) disable iff (reset)
		min_strobe |=> bcd_value(time_out.min_bcd) ==
			stepped(bcd_value($past(time_out.min_bcd)), int'(MINSEC_MAX) + 1, $past(up)))
	else begin
		$error("** Error at %0t: minute field stepped to the wrong value", $time);
		fail_count++;
	end

	a_sec_adjust: assert property (@(posedge clk) disable iff (reset)
		sec_strobe |=> bcd_value(time_out.sec_bcd) ==
			stepped(bcd_value($past(time_out.sec_bcd)), int'(MINSEC_MAX) + 1, $past(up)))
	else begin
		$error("** Error at %0t: second field stepped to the wrong value", $time);
		fail_count++;
	end

	a_hour_hold: assert property (@(posedge clk) disable iff (reset)
		(!running && !hour_strobe) |=> $stable(time_out.hour_bcd))
	else begin
		$error("** Error at %0t: hour field changed without a strobe", $time);
		fail_count++;
	end

	a_min_hold: assert property (@(posedge clk) disable iff (reset)
		(!running && !min_strobe) |=> $stable(time_out.min_bcd))
	else begin
		$error("** Error at %0t: minute field changed without a strobe", $time);
		fail_count++;
	end

	a_sec_hold: assert property (@(posedge clk) disable iff (reset)
		(!running && !sec_strobe) |=> $stable(time_out.sec_bcd))
	else begin
		$error("** Error at %0t: second field changed without a strobe", $time);
		fail_count++;
	end

	// ==============================
	// countdown
	// ==============================

	a_run_hold: assert property (@(posedge clk) disable iff (reset)
		(running && !dec_sec) |=> $stable(time_out))
	else begin
		$error("** Error at %0t: time changed while running without a tick", $time);
		fail_count++;
	end

	a_tick_step: assert property (@(posedge clk) disable iff (reset)
		dec_sec |=> total_seconds(time_out) == total_seconds($past(time_out)) - 1)
	else begin
		$error("** Error at %0t: countdown tick did not remove one second", $time);
		fail_count++;
	end

	a_start_run: assert property (@(posedge clk) disable iff (reset)
		(!running && !done && start && !clear) |=> running)
	else begin
		$error("** Error at %0t: start did not begin the countdown", $time);
		fail_count++;
	end

	a_zero_done: assert property (@(posedge clk) disable iff (reset)
		(running && !clear && (time_out == '0)) |=> done && !running && (time_out == '0))
	else begin
		$error("** Error at %0t: zero time did not end the countdown", $time);
		fail_count++;
	end

	a_done_hold: assert property (@(posedge clk) disable iff (reset)
		(done && !clear) |=> done)
	else begin
		$error("** Error at %0t: done dropped without clear", $time);
		fail_count++;
	end

	a_clear: assert property (@(posedge clk) disable iff (reset)
		clear |=> !done && !running)
	else begin
		$error("** Error at %0t: clear did not return to idle", $time);
		fail_count++;
	end

	a_digits: assert property (@(posedge clk) disable iff (reset)
		field_ok(time_out.hour_bcd, int'(HOUR_MAX)) && field_ok(time_out.min_bcd,
			int'(MINSEC_MAX)) && field_ok(time_out.sec_bcd, int'(MINSEC_MAX)))
	else begin
		$error("** Error at %0t: time digits out of range", $time);
		fail_count++;
	end

	a_reset: assert property (@(posedge clk)
		reset |=> (time_out == '0) && !running && !done)
	else begin
		$error("** Error at %0t: reset did not clear the timer", $time);
		fail_count++;
	end

endmodule

bind timer_top timer_assert timer_assert_inst (
	.clk      (clk),
	.reset    (reset),
	.field    (field),
	.up       (up),
	.down     (down),
	.start    (start),
	.clear    (clear),
	.time_out (time_out),
	.running  (running),
	.done     (done),
	.dec_sec  (dec_sec)
);

//--- design/timer_top.sv
`timescale 1ns/1ps

module timer_top
	import timer_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  field_sel_t field,
	input  logic       up,
	input  logic       down,
	input  logic       start,
	input  logic       clear,
	output time_bcd_t  time_out,
	output logic       running,
	output logic       done
);

	logic dec_sec;
	logic adj_en;
	logic sec_borrow;
	logic min_borrow;

	// ==============================
	// time fields
	// ==============================

	min_sec_counter #(.SELECT(FIELD_SEC)) sec_counter_inst (
		.clk       (clk),
		.reset     (reset),
		.field     (field),
		.up        (up),
		.down      (down),
		.adj_en    (adj_en),
		.dec       (dec_sec),
		.value_bcd (time_out.sec_bcd),
		.borrow    (sec_borrow)
	);

	min_sec_counter #(.SELECT(FIELD_MIN)) min_counter_inst (
		.clk       (clk),
		.reset     (reset),
		.field     (field),
		.up        (up),
		.down      (down),
		.adj_en    (adj_en),
		.dec       (sec_borrow), // seconds wrapped below zero
		.value_bcd (time_out.min_bcd),
		.borrow    (min_borrow)
	);

	hour_counter hour_counter_inst (
		.clk      (clk),
		.reset    (reset),
		.field    (field),
		.up       (up),
		.down     (down),
		.adj_en   (adj_en),
		.dec      (min_borrow),
		.hour_bcd (time_out.hour_bcd)
	);

	// ==============================
	// countdown control
	// ==============================

	countdown_ctrl countdown_ctrl_inst (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.clear   (clear),
		.time_in (time_out),
		.dec_sec (dec_sec),
		.adj_en  (adj_en),
		.running (running),
		.done    (done)
	);

endmodule

//--- design/countdown_ctrl.sv
`timescale 1ns/1ps

module countdown_ctrl
	import timer_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  logic      clear,
	input  time_bcd_t time_in,
	output logic      dec_sec,
	output logic      adj_en,
	output logic      running,
	output logic      done
);

	ctrl_state_t        state;
	ctrl_state_t        state_next;
	logic [PRESC_W-1:0] presc;
	logic               time_zero;
	logic               tick_point;

	assign time_zero  = (time_in == '0);
	assign tick_point = (presc == PRESC_LAST);

	// ==============================
	// state machine
	// ==============================

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		if (clear) begin
			state_next = ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (start) state_next = ST_RUN;
				ST_RUN:  if (time_zero) state_next = ST_DONE; // zero wins over a pending tick
				ST_DONE: state_next = ST_DONE; // held until clear
				default: state_next = ST_IDLE;
			endcase
		end
	end

	// ==============================
	// one-second prescaler
	// ==============================

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			presc <= '0;
		end else if ((state != ST_RUN) || tick_point) begin // idle keeps it at zero for start
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	assign dec_sec = (state == ST_RUN) && tick_point && !time_zero && !clear;

	assign running = (state == ST_RUN);
	assign done    = (state == ST_DONE);
	assign adj_en  = (state != ST_RUN); // fields are frozen while counting down

endmodule

//--- design/min_sec_counter.sv
`timescale 1ns/1ps

module min_sec_counter
	import timer_pkg::*;
#(
	parameter field_sel_t SELECT = FIELD_SEC
)
(
	input  logic       clk,
	input  logic       reset,
	input  field_sel_t field,
	input  logic       up,
	input  logic       down,
	input  logic       adj_en,
	input  logic       dec,
	output logic [7:0] value_bcd,
	output logic       borrow
);

	logic [5:0] count;
	logic [5:0] count_next;
	logic       selected;
	logic       at_zero;

	assign selected = adj_en && (field == SELECT);
	assign at_zero  = (count == '0);

	// the next field up takes one off in the same cycle
	assign borrow = dec && at_zero;

	// ==============================
	// field register
	// ==============================

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count_next;
		end
	end

	always_comb begin
		count_next = count;
		if (selected) begin
			if (up) begin
				if (count >= MINSEC_MAX) begin
					count_next = '0;
				end else begin
					count_next = count + 6'd1;
				end
			end else if (down) begin
				if (at_zero) begin
					count_next = MINSEC_MAX;
				end else begin
					count_next = count - 6'd1;
				end
			end
		end else if (dec) begin
			if (at_zero) begin // reload and pass the borrow on
				count_next = MINSEC_MAX;
			end else begin
				count_next = count - 6'd1;
			end
		end
	end

	// ==============================
	// BCD output
	// ==============================

	assign value_bcd = to_bcd(count);

endmodule

//--- design/hour_counter.sv
`timescale 1ns/1ps

module hour_counter
	import timer_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  field_sel_t field,
	input  logic       up,
	input  logic       down,
	input  logic       adj_en,
	input  logic       dec,
	output logic [7:0] hour_bcd
);

	logic [4:0] count;
	logic [4:0] count_next;
	logic       selected;

	assign selected = adj_en && (field == FIELD_HOUR);

	// ==============================
	// hour register
	// ==============================

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count_next;
		end
	end

	always_comb begin
		count_next = count;
		if (selected) begin
			if (up) begin
				if (count >= HOUR_MAX) begin // wrap 23 back to 00
					count_next = '0;
				end else begin
					count_next = count + 5'd1;
				end
			end else if (down) begin
				if (count == '0) begin
					count_next = HOUR_MAX;
				end else begin
					count_next = count - 5'd1;
				end
			end
		end else if (dec && (count != '0)) begin // hours are the top of the chain and never wrap
			count_next = count - 5'd1;
		end
	end

	// ==============================
	// BCD output
	// ==============================

	assign hour_bcd = to_bcd({1'b0, count});

endmodule

//--- design/timer_pkg.sv
package timer_pkg;

	// ==============================
	// field select codes
	// ==============================

	// codes outside 8..10 select no field
	typedef enum logic [3:0] {
		FIELD_SEC  = 4'd8,
		FIELD_MIN  = 4'd9,
		FIELD_HOUR = 4'd10
	} field_sel_t;

	// ==============================
	// time as BCD digit pairs
	// ==============================

	// each member holds tens in [7:4] and ones in [3:0]
	typedef struct packed {
		logic [7:0] hour_bcd;
		logic [7:0] min_bcd;
		logic [7:0] sec_bcd;
	} time_bcd_t;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1,
		ST_DONE = 2'd2
	} ctrl_state_t;

	// ==============================
	// limits and prescaler
	// ==============================

	localparam logic [4:0] HOUR_MAX   = 5'd23;
	localparam logic [5:0] MINSEC_MAX = 6'd59;

	// kept small so a countdown finishes in a short simulation
	localparam int TICKS_PER_SEC = 4;
	localparam int PRESC_W       = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
	localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(TICKS_PER_SEC - 1);

	// tens/ones split of a binary value below 60
	function automatic logic [7:0] to_bcd(input logic [5:0] value);
		logic [3:0] tens;
		logic [3:0] ones;
		tens = 4'(value / 6'd10);
		ones = 4'(value % 6'd10);
		return {tens, ones};
	endfunction

endpackage
